/* filelist.f */
+incdir+include
design/accel_pkg.sv
design/spi_tick_gen.sv
design/sample_sync_timer.sv
design/adxl355_reader.sv
design/sample_ram.sv
design/accel_capture_top.sv
dv/tb_clock_gen.sv
dv/adxl355_model.sv
dv/tb_accel_capture.sv

/* Makefile */
# Verilator build, run and lint for the accel capture testbench

VERILATOR ?= verilator
TOP       ?= tb_accel_capture
LINT_TOP  ?= accel_capture_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TESTBENCH FAILED" >> $(LOG)
	@cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_accel_capture.sv */
/* accel capture testbench
   runs read bursts against two sensor models, checks the ram contents,
   the pointer and the direct-mode pin handover */
`timescale 1ns/1ns
`default_nettype none
`include "accel_settings.svh"

module tb_accel_capture import accel_pkg::*; ();
  localparam int PERIOD     = `ACCEL_SYNC_PERIOD;
  localparam int DEPTH      = `ACCEL_RAM_DEPTH;
  localparam int SIDE_LEN   = `ACCEL_SIDE_BUF_LEN;
  localparam int NUM_BURSTS = 11;
  // wait for a sync, longest 15-byte burst, drain and readback
  localparam int BURST_CYC  = PERIOD + (15 * 16 + 3) * `ACCEL_TICK_DIV + 2 * 16 + 64;
  localparam int LIMIT      = NUM_BURSTS * BURST_CYC + 2 * PERIOD + 400;

  logic          clk;
  logic          rst_n;
  logic          sync_enable;
  logic          direct;
  byte_t         cmd;
  burst_len_t    len;
  logic          host_sclk;
  logic          host_csn;
  logic          host_mosi;
  logic          adxl0_miso;
  logic          adxl1_miso;
  ram_addr_t     rd_addr = '0;
  logic          adxl_sclk;
  logic          adxl_csn;
  logic          adxl_mosi;
  logic          host_miso;
  logic          direct_en;
  logic          busy;
  sample_entry_t rd_entry;
  ram_addr_t     wr_ptr;

  integer        seed = 32'h1488_629d;
  string         test_name = "none";
  int            errors = 0;
  int            checks = 0;
  int            tests = 0;
  int            failed_tests = 0;
  int            test_errs = 0;
  int            bursts_started = 0;
  int            bursts_checked = 0;
  int            cycles = 0;
  ram_addr_t     exp_ptr = '0;      // where the next burst should land
  sample_entry_t exp_q[$];
  logic          busy_seen = 1'b0;
  logic          any_busy;
  byte_t         host_cmd;
  byte_t         host_rx;

  tb_clock_gen i_tb_clock_gen (.clk, .rst_n);

  accel_capture_top i_accel_capture_top (.*);

  adxl355_model i_adxl355_model (
    .sclk(adxl_sclk), .csn(adxl_csn), .mosi(adxl_mosi),
    .miso0(adxl0_miso), .miso1(adxl1_miso)
  );

  function automatic byte_t sensor_byte(byte_t c, int k, logic chip);
    return c ^ byte_t'(k * 8'h13) ^ (chip ? 8'h5a : 8'h00);
  endfunction

  // expected ram entries of one burst, chip 0 first then the side buffer
  function automatic void build_expected(byte_t c, burst_len_t l);
    sample_entry_t e;
    int            n1;
    exp_q.delete();
    n1 = 0;
    for (int k = 1; k < int'(l); k++)
      if (k % 3 != 0)
      begin
        e.x_start = (k == 1);
        e.data    = sensor_byte(c, k, 1'b0);
        exp_q.push_back(e);
      end
    for (int k = 1; k < int'(l); k++)
      if (k % 3 != 0 && n1 < SIDE_LEN)
      begin
        e.x_start = 1'b0;
        e.data    = sensor_byte(c, k, 1'b1);
        exp_q.push_back(e);
        n1++;
      end
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_errs)
      $display("test %-14s ok", test_name);
    else
    begin
      failed_tests++;
      $display("test %-14s %0d mismatches", test_name, errors - test_errs);
    end
  endtask

  // one sync only, enable drops once the burst is running
  task automatic launch_burst(input burst_len_t l);
    cmd = byte_t'($random(seed)) | 8'h01;  // read bit
    len = l;
    build_expected(cmd, l);
    sync_enable = 1'b1;
    wait (busy);
    @(negedge clk);
    sync_enable = 1'b0;
    bursts_started++;
  endtask

  task automatic run_burst(input string name, input burst_len_t l);
    start_test(name);
    launch_burst(l);
    wait (bursts_checked == bursts_started);
    @(negedge clk);
    end_test();
  endtask

  // mode 0 host byte, miso read before each rising sclk
  task automatic host_byte(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--)
    begin
      host_mosi = tx[i];
      @(negedge clk);
      rx[i]     = host_miso;
      host_sclk = 1'b1;
      @(negedge clk);
      compare_value("adxl_sclk follows host", 32'd1, 32'(adxl_sclk));
      host_sclk = 1'b0;
      @(negedge clk);
    end
  endtask

  // readback after every burst end, busy sampled at the falling edge
  initial
  begin : readback
    forever
    begin
      @(negedge clk);
      if (busy_seen && !busy)
      begin
        for (int i = 0; i < exp_q.size(); i++)
        begin
          rd_addr = ram_addr_t'((int'(exp_ptr) + i) % DEPTH);
          @(negedge clk);
          compare_value($sformatf("entry %0d", i), 32'(exp_q[i]), 32'(rd_entry));
        end
        exp_ptr = ram_addr_t'((int'(exp_ptr) + exp_q.size()) % DEPTH);
        compare_value("wr_ptr", 32'(exp_ptr), 32'(wr_ptr));
        bursts_checked++;
      end
      busy_seen = busy;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("timeout: no result after %0d cycles in test %s", LIMIT, test_name);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial
  begin
    sync_enable = 1'b0;
    direct      = 1'b0;
    cmd         = '0;
    len         = '0;
    host_sclk   = 1'b0;
    host_csn    = 1'b1;
    host_mosi   = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    start_test("reset_state");
    compare_value("wr_ptr", 32'd0, 32'(wr_ptr));
    compare_value("busy, direct_en", 32'd0, 32'({busy, direct_en}));
    compare_value("adxl_csn, adxl_sclk", 32'b10, 32'({adxl_csn, adxl_sclk}));
    end_test();

    run_burst("len10", 4'd10);
    run_burst("len7", 4'd7);
    run_burst("len13", 4'd13);

    // request mid-burst, grant only after busy falls
    start_test("direct_grant");
    launch_burst(4'd10);
    repeat (20) @(negedge clk);
    direct = 1'b1;
    while (busy)
    begin
      compare_value("direct_en while busy", 32'd0, 32'(direct_en));
      @(negedge clk);
    end
    wait (bursts_checked == bursts_started);
    wait (direct_en);
    @(negedge clk);
    host_csn = 1'b0;
    @(negedge clk);
    compare_value("adxl pins follow host", 32'({host_sclk, host_csn, host_mosi}),
                  32'({adxl_sclk, adxl_csn, adxl_mosi}));
    host_cmd = byte_t'($random(seed)) | 8'h01;
    host_byte(host_cmd, host_rx);
    host_byte(8'h00, host_rx);
    compare_value("host_miso byte 1", 32'(sensor_byte(host_cmd, 1, 1'b0)), 32'(host_rx));
    host_csn    = 1'b1;
    any_busy    = 1'b0;
    sync_enable = 1'b1;  // a sync lands here and must be ignored
    repeat (PERIOD + 20)
    begin
      @(negedge clk);
      any_busy = any_busy | busy;
    end
    sync_enable = 1'b0;
    compare_value("busy under direct", 32'd0, 32'(any_busy));
    compare_value("wr_ptr under direct", 32'(exp_ptr), 32'(wr_ptr));
    end_test();

    direct = 1'b0;
    wait (!direct_en);
    @(negedge clk);
    run_burst("after_direct", 4'd10);

    // random lengths carry the pointer past the end of the ram
    for (int i = 0; i < 6; i++)
      run_burst($sformatf("wrap_%0d", i), burst_len_t'(4 + $unsigned($random(seed)) % 12));

    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/adxl355_model.sv */
/* adxl355 sensor pair model
   mode 0 spi slaves on one sclk/csn/mosi, each answering on its own miso */
`timescale 1ns/1ns
`default_nettype none

module adxl355_model import accel_pkg::*; (
  input  wire  sclk,
  input  wire  csn,
  input  wire  mosi,
  output logic miso0,
  output logic miso1
);
  byte_t      cmd_sr   = '0;  // command as it arrives
  int         rise_cnt = 0;
  int         fall_cnt = 0;   // bits already shifted out
  int         k;
  logic [2:0] bit_pos;
  byte_t      r0;
  byte_t      r1;

  // byte k of a chip, the command slot answers zero
  function automatic byte_t answer(byte_t c, int kk, logic chip);
    if (kk == 0)
      return 8'h00;
    return c ^ byte_t'(kk * 8'h13) ^ (chip ? 8'h5a : 8'h00);
  endfunction

  always @(posedge sclk or posedge csn)
    if (csn)
    begin
      rise_cnt <= 0;
      cmd_sr   <= '0;
    end
    else
    begin
      if (rise_cnt < 8)
        cmd_sr <= {cmd_sr[6:0], mosi};  // only the first byte is a command
      rise_cnt <= rise_cnt + 1;
    end

  always @(posedge csn or negedge sclk)
    if (csn)
      fall_cnt <= 0;
    else
      fall_cnt <= fall_cnt + 1;  // next bit goes out on the fall

  always_comb
  begin
    k       = fall_cnt >> 3;
    bit_pos = ~fall_cnt[2:0];    // msb first
    r0      = answer(cmd_sr, k, 1'b0);
    r1      = answer(cmd_sr, k, 1'b1);
    miso0   = (csn == 1'b0) ? r0[bit_pos] : 1'b0;
    miso1   = (csn == 1'b0) ? r1[bit_pos] : 1'b0;
  end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
/* testbench clock and reset
   8 ns clock, active-low reset held for the first 10 cycles */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);
  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // released away from the active edge
  end

endmodule

`default_nettype wire

/* design/accel_capture_top.sv */
/* accel capture top
   tick, sync, reader and sample ram, plus the host/reader spi pin mux */
`timescale 1ns/1ns
`default_nettype none

module accel_capture_top import accel_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                sync_enable,
  input  wire                direct,
  input  wire byte_t         cmd,
  input  wire burst_len_t    len,
  input  wire                host_sclk,
  input  wire                host_csn,
  input  wire                host_mosi,
  input  wire                adxl0_miso,
  input  wire                adxl1_miso,
  input  wire ram_addr_t     rd_addr,
  output logic               adxl_sclk,
  output logic               adxl_csn,
  output logic               adxl_mosi,
  output logic               host_miso,
  output wire                direct_en,
  output wire                busy,
  output wire sample_entry_t rd_entry,
  output wire ram_addr_t     wr_ptr
);
  logic          tick;
  logic          sync;
  logic          rd_sclk;
  logic          rd_csn;
  logic          rd_mosi;
  logic          wr_en;
  sample_entry_t wr_entry;

  spi_tick_gen i_spi_tick_gen (.clk, .rst_n, .tick);

  sample_sync_timer i_sample_sync_timer (.clk, .rst_n, .enable(sync_enable), .sync);

  adxl355_reader i_adxl355_reader (
    .clk, .rst_n, .tick, .sync, .direct, .cmd, .len,
    .adxl0_miso, .adxl1_miso,
    .rd_sclk, .rd_csn, .rd_mosi,
    .wr_en, .wr_entry, .direct_en, .busy
  );

  sample_ram i_sample_ram (.clk, .rst_n, .wr_en, .wr_entry, .rd_addr, .rd_entry, .wr_ptr);

  // host owns the bus only while granted
  assign adxl_sclk = direct_en ? host_sclk : rd_sclk;
  assign adxl_csn  = direct_en ? host_csn  : rd_csn;
  assign adxl_mosi = direct_en ? host_mosi : rd_mosi;
  assign host_miso = adxl0_miso;  // chip 0 only, no mux needed

endmodule

`default_nettype wire

/* design/sample_ram.sv */
/* sample ram
   circular store of tagged sample bytes, host reads by address */
`timescale 1ns/1ns
`default_nettype none
`include "accel_settings.svh"

module sample_ram import accel_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                wr_en,
  input  wire sample_entry_t wr_entry,
  input  wire ram_addr_t     rd_addr,   // host side
  output sample_entry_t      rd_entry,
  output ram_addr_t          wr_ptr     // next slot to be written
);
  localparam int DEPTH = `ACCEL_RAM_DEPTH;

  sample_entry_t mem [DEPTH];

  always_ff @(posedge clk)
    if (wr_en)
      mem[wr_ptr] <= wr_entry;

  // no back-pressure, oldest entries get overwritten
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      wr_ptr <= '0;
    else if (wr_en)
      wr_ptr <= (wr_ptr == ram_addr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

  assign rd_entry = mem[rd_addr];  // combinational host read

endmodule

`default_nettype wire

/* design/adxl355_reader.sv */
/* adxl355 burst reader
   spi master for two sensors on one bus, keeps the 16-bit sample stream
   and appends the chip-1 bytes from a side buffer after the burst */
`timescale 1ns/1ns
`default_nettype none
`include "accel_settings.svh"

module adxl355_reader import accel_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             tick,        // spi step
  input  wire             sync,        // burst request
  input  wire             direct,      // host wants the pins
  input  wire byte_t      cmd,         // sent first, read bit set by caller
  input  wire burst_len_t len,         // bytes incl. command
  input  wire             adxl0_miso,
  input  wire             adxl1_miso,
  output logic            rd_sclk,
  output logic            rd_csn,
  output logic            rd_mosi,
  output logic            wr_en,
  output sample_entry_t   wr_entry,
  output logic            direct_en,   // grant for the pin mux
  output logic            busy
);
  localparam int SIDE_LEN = `ACCEL_SIDE_BUF_LEN;
  localparam int SIDE_W   = $clog2(SIDE_LEN + 1);

  logic [7:0]        index;  // {byte, bit, half}, offset by one
  burst_len_t        len_r;
  byte_t             cmd_r;
  byte_t             mosi_sr;
  byte_t             miso0_sr;
  byte_t             miso1_sr;
  byte_t             side_buf [SIDE_LEN];
  logic [SIDE_W-1:0] wcnt;   // chip-1 bytes held
  logic [SIDE_W-1:0] rcnt;   // chip-1 bytes drained
  drain_state_t      drain_state;

  logic [7:0] last_bit_idx;
  logic [7:0] end_idx;
  logic [7:0] pos;
  logic       in_bits;
  logic       start;
  logic       csn_rise;
  logic       byte_done;
  logic       keep_wr;
  burst_len_t k;
  byte_t      byte0;
  byte_t      byte1;

  // 16-bit stream: skip the command and every low byte of a 20-bit axis
  function automatic logic keep_byte(burst_len_t kb);
    keep_byte = (kb != '0) && (kb % 3 != 0);
  endfunction

  assign last_bit_idx = {len_r, 4'h0};         // final falling edge
  assign end_idx      = last_bit_idx + 8'd2;   // parked here when idle
  assign pos          = index - 8'd1;          // pos[0]: 0 rise, 1 fall
  assign in_bits      = (index != 8'd0) && (index <= last_bit_idx);
  assign start        = sync && !busy && !direct_en;  // late syncs are dropped
  assign csn_rise     = tick && (index == last_bit_idx + 8'd1);
  assign byte_done    = tick && in_bits && !pos[0] && (pos[3:1] == 3'd7);
  assign k            = pos[7:4];              // byte number in the burst
  assign keep_wr      = byte_done && keep_byte(k);
  assign byte0        = {miso0_sr[6:0], adxl0_miso};
  assign byte1        = {miso1_sr[6:0], adxl1_miso};
  assign rd_mosi      = mosi_sr[7];            // msb first
  assign busy         = (index != end_idx) || (drain_state == drain_run) || wr_en;

  // running index, advanced by tick until parked at end_idx
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      index <= 8'd2;  // empty burst, already parked
      len_r <= '0;
    end
    else if (start)
    begin
      index <= '0;
      len_r <= len;
    end
    else if (tick && index != end_idx)
      index <= index + 8'd1;

  always_ff @(posedge clk)
    if (start)
      cmd_r <= cmd;

  // mode 0 pins, sclk idles low and mosi moves on falling edges
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      rd_csn  <= 1'b1;
      rd_sclk <= 1'b0;
      mosi_sr <= '0;
    end
    else if (tick)
    begin
      if (index == 8'd0)
      begin
        rd_csn  <= 1'b0;   // one tick after start
        mosi_sr <= cmd_r;
      end
      else if (csn_rise)
        rd_csn <= 1'b1;
      rd_sclk <= in_bits && !pos[0];
      if (in_bits && pos[0])
        mosi_sr <= {mosi_sr[6:0], 1'b0};  // zeros after the command
    end

  // miso sampled as sclk rises
  always_ff @(posedge clk)
    if (tick && in_bits && !pos[0])
    begin
      miso0_sr <= byte0;
      miso1_sr <= byte1;
    end

  always_ff @(posedge clk)
    if (keep_wr && wcnt < SIDE_W'(SIDE_LEN))
      side_buf[wcnt] <= byte1;  // first six only

  // side buffer fill count and drain fsm
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      wcnt        <= '0;
      rcnt        <= '0;
      drain_state <= drain_idle;
    end
    else
    begin
      if (start)
        wcnt <= '0;
      else if (keep_wr && wcnt < SIDE_W'(SIDE_LEN))
        wcnt <= wcnt + 1'b1;
      case (drain_state)
        drain_idle:
          if (csn_rise && wcnt != '0)
          begin
            drain_state <= drain_run;
            rcnt        <= '0;
          end
        drain_run:
        begin
          rcnt <= rcnt + 1'b1;  // one byte per clk
          if (rcnt == wcnt - 1'b1)
            drain_state <= drain_idle;
        end
        default: drain_state <= drain_idle;
      endcase
    end

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      wr_en <= 1'b0;
    else
      wr_en <= (drain_state == drain_run) || keep_wr;

  // drain and chip-0 writes never overlap, drain runs after csn rises
  always_ff @(posedge clk)
    if (drain_state == drain_run)
      wr_entry <= '{x_start: 1'b0, data: side_buf[rcnt]};
    else if (keep_wr)
      wr_entry <= '{x_start: (k == 4'd1), data: byte0};

  // grant moves only while idle and not while a burst is being started
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      direct_en <= 1'b0;
    else if (!busy && !start)
      direct_en <= direct;

  a_csn_high_in_direct: assert property (@(posedge clk) disable iff (!rst_n)
    direct_en |-> rd_csn);
  a_no_write_in_direct: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wr_en) |-> !direct_en);

endmodule

`default_nettype wire

/* design/sample_sync_timer.sv */
/* sample sync timer
   periodic one-cycle pulse that starts a read burst, paused by enable */
`timescale 1ns/1ns
`default_nettype none
`include "accel_settings.svh"

module sample_sync_timer (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  enable,   // counter holds while low
  output logic sync
);
  localparam int PERIOD = `ACCEL_SYNC_PERIOD;
  localparam int CNT_W  = $clog2(PERIOD);

  logic [CNT_W-1:0] cnt;
  logic             wrap;

  assign wrap = (cnt == CNT_W'(PERIOD - 1));  // last cycle of the period

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      cnt  <= '0;
      sync <= 1'b0;
    end
    else
    begin
      sync <= enable && wrap;
      if (enable)
        cnt <= wrap ? '0 : cnt + 1'b1;
    end

  // a burst request is a strobe, never a level
  a_sync_pulse: assert property (@(posedge clk) disable iff (!rst_n) sync |=> !sync);

endmodule

`default_nettype wire

/* design/spi_tick_gen.sv */
/* spi tick generator
   one-cycle tick every ACCEL_TICK_DIV clk cycles */
`timescale 1ns/1ns
`default_nettype none
`include "accel_settings.svh"

module spi_tick_gen (
  input  wire  clk,
  input  wire  rst_n,
  output logic tick    // one clk wide
);
  localparam int DIV   = `ACCEL_TICK_DIV;
  localparam int CNT_W = $clog2(DIV);

  logic [CNT_W-1:0] cnt;  // counts down to zero

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      cnt  <= CNT_W'(DIV - 1);
      tick <= 1'b0;
    end
    else
    begin
      tick <= (cnt == '0);
      cnt  <= (cnt == '0) ? CNT_W'(DIV - 1) : cnt - 1'b1;  // reload at zero
    end

  // reader steps once per tick, a double tick would skip an sclk half
  a_tick_single: assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick);

endmodule

`default_nettype wire

/* design/accel_pkg.sv */
/* accel capture shared types
   byte and length vectors, the tagged ram entry and the drain fsm states */
`default_nettype none
`include "accel_settings.svh"

package accel_pkg;

  typedef logic [7:0] byte_t;       // spi or sample byte
  typedef logic [3:0] burst_len_t;  // burst length incl. command byte

  // sample ram address
  typedef logic [$clog2(`ACCEL_RAM_DEPTH)-1:0] ram_addr_t;

  // one stored byte, x_start marks the first x-axis byte of a burst
  typedef struct packed {
    logic  x_start;
    byte_t data;
  } sample_entry_t;

  // side buffer drain after csn rises
  typedef enum logic {
    drain_idle,
    drain_run
  } drain_state_t;

endpackage

`default_nettype wire

/* include/accel_settings.svh */
/* accel capture build settings
   tick divider, sync period, sample ram depth and side buffer length */
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// clk cycles per spi tick, one sclk bit takes two ticks
`define ACCEL_TICK_DIV 4

// clk cycles between burst-start syncs
`define ACCEL_SYNC_PERIOD 400

// sample ram entries, power of two keeps the pointer wrap natural
`define ACCEL_RAM_DEPTH 64

// chip-1 bytes held back until the burst ends
`define ACCEL_SIDE_BUF_LEN 6

`endif
